/* project.f */
tcdm_pkg.sv
tcdm_rotation_ctrl.sv
tcdm_reorder.sv
tcdm_bank.sv
tcdm_subsystem.sv
tb_tcdm_subsystem.sv

/* run.sh */
#!/bin/sh
# Build and run the TCDM subsystem testbench with Verilator.
# Exit status is non-zero when the build or the run fails.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=tb_tcdm_subsystem

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert -f project.f \
  --top-module "$TOP" --Mdir "$BUILD_DIR" -o sim_"$TOP"
if [ $? -ne 0 ]; then
  echo "compilation failed"
  exit 1
fi

"./$BUILD_DIR/sim_$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF '*** TEST FAILED ***' "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi

echo "simulation finished without a reported failure"
exit 0

/* tb_tcdm_subsystem.sv */
// ----------------------------------------------------------
// tcdm subsystem testbench
// Table-driven transfers checked against a reference model
// of the banks, plus all-channel bursts, rotation and clear.
// ----------------------------------------------------------

module tb_tcdm_subsystem;

  localparam int NB_CHAN    = tcdm_pkg::nb_chan_default;
  localparam int BANK_DEPTH = tcdm_pkg::bank_depth_default;
  localparam int ORDER_W    = $clog2(NB_CHAN);
  localparam int DW         = tcdm_pkg::data_w;
  localparam int AW         = tcdm_pkg::addr_w;
  localparam int BE         = tcdm_pkg::be_w;
  localparam int TIMEOUT    = 20;  // cycles allowed per wait.
  localparam int N_ROWS     = 12;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       clear;
  logic                       rotate_en;
  logic [NB_CHAN-1:0]         req;
  logic [NB_CHAN-1:0][AW-1:0] add;
  logic [NB_CHAN-1:0]         wen;
  logic [NB_CHAN-1:0][BE-1:0] be;
  logic [NB_CHAN-1:0][DW-1:0] data;
  logic [NB_CHAN-1:0]         gnt;
  logic [NB_CHAN-1:0][DW-1:0] r_data;
  logic [NB_CHAN-1:0]         r_valid;
  logic [ORDER_W-1:0]         order;

  logic [DW-1:0] ref_mem [NB_CHAN][BANK_DEPTH];  // model of every bank.
  int            pred_order;                     // order the DUT should show.
  int            errors;
  int            tests_run;
  int            tests_failed;
  bit            timed_out;
  int            seed;

  // one table row per transfer with channel, read flag, address, byte enable,
  // write data, rotate_en and the expected read data.
  int          t_chan [N_ROWS];
  bit          t_rd   [N_ROWS];
  logic [AW-1:0] t_addr [N_ROWS];
  logic [BE-1:0] t_be   [N_ROWS];
  logic [DW-1:0] t_data [N_ROWS];
  bit          t_rot  [N_ROWS];
  logic [DW-1:0] t_exp  [N_ROWS];

  tcdm_subsystem #(
    .NB_CHAN    (NB_CHAN),
    .BANK_DEPTH (BANK_DEPTH)
  ) uut (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .clear     (clear),
    .rotate_en (rotate_en),
    .req       (req),
    .add       (add),
    .wen       (wen),
    .be        (be),
    .data      (data),
    .gnt       (gnt),
    .r_data    (r_data),
    .r_valid   (r_valid),
    .order     (order)
  );

  always #2 clk_i = ~clk_i;  // period of 4.

  // bank reached by a channel under a given rotation.
  function automatic int bank_of(input int chan, input int ord);
    return (chan + NB_CHAN - ord) % NB_CHAN;
  endfunction

  // enabled byte lanes take the new data.
  function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old_w,
                                                input logic [DW-1:0] new_w,
                                                input logic [BE-1:0] be_v);
    logic [DW-1:0] res;
    res = old_w;
    for (int b = 0; b < BE; b++) begin
      if (be_v[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic report_error(input string what, input logic [DW-1:0] got,
                              input logic [DW-1:0] exp);
    $display("[ERROR] t=%0t: %s is %h, expected %h", $time, what, got, exp);
    errors++;
  endtask

  task automatic end_test(input string name, input int err0);
    tests_run++;
    if (errors > err0) begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, errors - err0);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
  endtask

  task automatic add_row(input int idx, input int chan, input bit rd,
                         input logic [AW-1:0] a, input logic [BE-1:0] b,
                         input logic [DW-1:0] d, input bit rot, input logic [DW-1:0] exp);
    t_chan[idx] = chan;
    t_rd[idx]   = rd;
    t_addr[idx] = a;
    t_be[idx]   = b;
    t_data[idx] = d;
    t_rot[idx]  = rot;
    t_exp[idx]  = exp;
  endtask

  task automatic fill_table();
    add_row(0, 0, 1'b0, 8'h10, 4'hf, 32'h1122_3344, 1'b0, 32'h0);  // order stays 0.
    add_row(1, 0, 1'b1, 8'h10, 4'hf, 32'h0, 1'b0, 32'h1122_3344);
    add_row(2, 1, 1'b0, 8'h20, 4'hf, 32'ha5a5_0001, 1'b1, 32'h0);  // bank 1 then order 1.
    add_row(3, 2, 1'b1, 8'h20, 4'hf, 32'h0, 1'b0, 32'ha5a5_0001);  // same bank 1.
    add_row(4, 2, 1'b0, 8'h30, 4'hf, 32'hcafe_0002, 1'b1, 32'h0);  // order to 2.
    add_row(5, 3, 1'b1, 8'h30, 4'hf, 32'h0, 1'b1, 32'hcafe_0002);  // order to 3.
    add_row(6, 0, 1'b1, 8'h30, 4'hf, 32'h0, 1'b1, 32'hcafe_0002);  // order wraps to 0.
    add_row(7, 1, 1'b1, 8'h20, 4'hf, 32'h0, 1'b0, 32'ha5a5_0001);
    add_row(8, 3, 1'b0, 8'h40, 4'hf, 32'h0000_0000, 1'b0, 32'h0);
    add_row(9, 3, 1'b0, 8'h40, 4'h5, 32'haabb_ccdd, 1'b0, 32'h0);  // lanes 0 and 2.
    add_row(10, 3, 1'b0, 8'h40, 4'h8, 32'h7700_0000, 1'b0, 32'h0);
    add_row(11, 3, 1'b1, 8'h40, 4'hf, 32'h0, 1'b0, 32'h77bb_00dd);
  endtask

  // grant sampled mid-cycle while the request is held.
  task automatic wait_gnt(input logic [NB_CHAN-1:0] mask);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while ((gnt & mask) != mask && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if ((gnt & mask) != mask) begin
      $display("timeout: channels %b got no grant within %0d cycles", mask, TIMEOUT);
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_rvalid(input int chan, output int cycles);
    cycles = 1;
    @(negedge clk_i);
    while (!r_valid[chan] && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!r_valid[chan]) begin
      $display("timeout: channel %0d got no response within %0d cycles", chan, TIMEOUT);
      timed_out = 1'b1;
    end
  endtask

  // one request on one channel checked against the model.
  task automatic single_transfer(input int chan, input bit rd, input logic [AW-1:0] a,
                                 input logic [BE-1:0] b, input logic [DW-1:0] d,
                                 input bit rot, output logic [DW-1:0] got);
    logic [NB_CHAN-1:0] mask;
    logic [DW-1:0]      exp;
    int                 bank;
    int                 lat;
    mask       = '0;
    mask[chan] = 1'b1;
    got        = '0;
    @(posedge clk_i);
    req[chan]  <= 1'b1;
    add[chan]  <= a;
    wen[chan]  <= rd;
    be[chan]   <= b;
    data[chan] <= d;
    rotate_en  <= rot;
    wait_gnt(mask);
    if (timed_out) return;
    if (order !== ORDER_W'(pred_order)) report_error("order at acceptance", DW'(order),
                                                     DW'(pred_order));
    bank = bank_of(chan, pred_order);
    exp  = ref_mem[bank][a];
    if (!rd) begin
      ref_mem[bank][a] = merge_bytes(ref_mem[bank][a], d, b);
    end
    if (rot) begin
      pred_order = (pred_order + 1) % NB_CHAN;  // served cycle with rotation on.
    end
    @(posedge clk_i);
    req[chan] <= 1'b0;  // a rotation left on over this idle cycle must not move order.
    wait_rvalid(chan, lat);
    if (timed_out) return;
    if (lat != 1) report_error("response latency", DW'(lat), DW'(1));
    if (r_valid !== mask) report_error("r_valid vector", DW'(r_valid), DW'(mask));
    if (order !== ORDER_W'(pred_order)) report_error("order after acceptance", DW'(order),
                                                     DW'(pred_order));
    got = r_data[chan];
    if (rd && got !== exp) report_error($sformatf("ch %0d read data", chan), got, exp);
  endtask

  task automatic check_reset_state();
    int err0;
    err0 = errors;
    @(negedge clk_i);
    if (order !== '0) report_error("order after reset", DW'(order), '0);
    if (r_valid !== '0) report_error("r_valid after reset", DW'(r_valid), '0);
    end_test("reset state", err0);
  endtask

  task automatic apply_table();
    logic [DW-1:0] got;
    int            err0;
    for (int r = 0; r < N_ROWS; r++) begin
      err0 = errors;
      single_transfer(t_chan[r], t_rd[r], t_addr[r], t_be[r], t_data[r], t_rot[r], got);
      if (timed_out) break;
      if (t_rd[r] && got !== t_exp[r]) report_error($sformatf("row %0d table data", r),
                                                    got, t_exp[r]);
      end_test($sformatf("row %0d ch %0d %s addr %h", r, t_chan[r],
                         t_rd[r] ? "read" : "write", t_addr[r]), err0);
    end
  endtask

  // one write burst then three read bursts while order moves every cycle.
  task automatic all_channel_burst();
    logic [DW-1:0] wdata [NB_CHAN];
    logic [DW-1:0] exp_q [NB_CHAN];
    int            err0;
    int            bank;
    int            lat;
    err0 = errors;
    for (int c = 0; c < NB_CHAN; c++) begin
      wdata[c] = $random(seed);
      exp_q[c] = '0;
    end
    for (int k = 0; k < 4; k++) begin
      @(posedge clk_i);
      req       <= '1;
      wen       <= (k == 0) ? '0 : '1;
      rotate_en <= 1'b1;
      for (int c = 0; c < NB_CHAN; c++) begin
        add[c]  <= 8'h50;
        be[c]   <= '1;
        data[c] <= wdata[c];
      end
      wait_gnt('1);
      if (timed_out) return;
      if (order !== ORDER_W'(pred_order)) report_error("burst order", DW'(order),
                                                       DW'(pred_order));
      if (k > 0 && r_valid !== '1) report_error("burst r_valid", DW'(r_valid), DW'(4'hf));
      for (int c = 0; c < NB_CHAN; c++) begin
        if (k > 1 && r_data[c] !== exp_q[c]) report_error($sformatf("burst ch %0d data", c),
                                                          r_data[c], exp_q[c]);
        bank = bank_of(c, pred_order);
        if (k == 0) begin
          ref_mem[bank][8'h50] = wdata[c];
        end else begin
          exp_q[c] = ref_mem[bank][8'h50];  // neighbour's word after a shift.
        end
      end
      pred_order = (pred_order + 1) % NB_CHAN;
    end
    @(posedge clk_i);
    req       <= '0;
    rotate_en <= 1'b0;
    wait_rvalid(0, lat);
    if (timed_out) return;
    if (lat != 1) report_error("burst tail latency", DW'(lat), DW'(1));
    if (r_valid !== '1) report_error("burst tail r_valid", DW'(r_valid), DW'(4'hf));
    for (int c = 0; c < NB_CHAN; c++) begin
      if (r_data[c] !== exp_q[c]) report_error($sformatf("burst tail ch %0d data", c),
                                               r_data[c], exp_q[c]);
    end
    end_test("all channels with rotation", err0);
  endtask

  task automatic clear_in_flight();
    logic [NB_CHAN-1:0] mask;
    logic [DW-1:0]      got;
    logic [DW-1:0]      wd;
    int                 err0;
    int                 bank;
    err0 = errors;
    single_transfer(1, 1'b0, 8'h60, '1, 32'h1357_9bdf, 1'b1, got);  // order off zero.
    if (timed_out) return;
    wd      = $random(seed);
    mask    = '0;
    mask[2] = 1'b1;
    @(posedge clk_i);
    req[2]    <= 1'b1;
    add[2]    <= 8'h61;
    wen[2]    <= 1'b0;
    be[2]     <= '1;
    data[2]   <= wd;
    rotate_en <= 1'b1;
    clear     <= 1'b1;  // same cycle as the acceptance.
    wait_gnt(mask);
    if (timed_out) return;
    if (order !== ORDER_W'(pred_order)) report_error("order before clear", DW'(order),
                                                     DW'(pred_order));
    bank = bank_of(2, pred_order);
    ref_mem[bank][8'h61] = wd;
    pred_order = 0;
    @(posedge clk_i);
    req[2]    <= 1'b0;
    rotate_en <= 1'b0;
    clear     <= 1'b0;
    @(negedge clk_i);
    if (order !== '0) report_error("order after clear", DW'(order), '0);
    if (r_valid !== '0) report_error("r_valid after clear", DW'(r_valid), '0);
    // the write still landed and order 0 maps channel n to bank n.
    single_transfer(bank, 1'b1, 8'h61, '1, '0, 1'b0, got);
    if (!timed_out && got !== wd) report_error("data written during clear", got, wd);
    end_test("clear", err0);
  endtask

  initial begin : main
    clk_i        = 1'b0;
    rst_ni       <= 1'b0;
    clear        <= 1'b0;
    rotate_en    <= 1'b0;
    req          <= '0;
    add          <= '0;
    wen          <= '0;
    be           <= '0;
    data         <= '0;
    seed         = 32'h0956caed;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    pred_order   = 0;
    fill_table();
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    check_reset_state();
    if (!timed_out) apply_table();
    if (!timed_out) all_channel_burst();
    if (!timed_out) clear_in_flight();
    $display("tests run %0d, passed %0d, failed %0d, errors %0d", tests_run,
             tests_run - tests_failed, tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule : tb_tcdm_subsystem

/* tcdm_bank.sv */
// ----------------------------------------------------------
// tcdm bank
// Single-port word memory with byte-enabled writes. Grants
// every request at once and answers one cycle later.
// ----------------------------------------------------------

module tcdm_bank #(
  parameter int unsigned BANK_DEPTH = tcdm_pkg::bank_depth_default
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear,
  input  logic                        req,
  input  logic [tcdm_pkg::addr_w-1:0] add,   // word address.
  input  logic                        wen,   // 1 reads, 0 writes.
  input  logic [tcdm_pkg::be_w-1:0]   be,
  input  logic [tcdm_pkg::data_w-1:0] data,
  output logic                        gnt,
  output logic [tcdm_pkg::data_w-1:0] r_data,
  output logic                        r_valid
);

  localparam int unsigned IDX_W = $clog2(BANK_DEPTH);

  logic [tcdm_pkg::data_w-1:0] mem [BANK_DEPTH];
  logic [IDX_W-1:0]            idx;     // row actually addressed.
  logic                        accept;  // handshake done this cycle.

  assign gnt    = req;  // no conflicts at a bank, so never stalls.
  assign accept = req & gnt;
  assign idx    = add[IDX_W-1:0];

  // byte lanes written one by one.
  always_ff @(posedge clk_i) begin : mem_write
    if (accept && !wen) begin
      for (int b = 0; b < tcdm_pkg::be_w; b++) begin
        if (be[b]) begin
          mem[idx][8*b +: 8] <= data[8*b +: 8];
        end
      end
    end
  end

  // read port holds its data until the next read.
  always_ff @(posedge clk_i) begin : mem_read
    if (accept && wen) begin
      r_data <= mem[idx];
    end
  end

  // one response per accepted request for reads and writes alike.
  always_ff @(posedge clk_i or negedge rst_ni) begin : valid_reg
    if (!rst_ni) begin
      r_valid <= 1'b0;
    end else if (clear) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= accept;
    end
  end

  // upper address bits are not decoded, so they must stay in range.
  addr_range_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    accept |-> (int'(add) < BANK_DEPTH)
  ) else $error("bank address %0d beyond depth %0d.", add, BANK_DEPTH);

endmodule : tcdm_bank

/* tcdm_pkg.sv */
// ----------------------------------------------------------
// tcdm package
// Widths and defaults shared by the TCDM slice and its
// testbench: data word, byte enables, bank address and the
// default channel count and bank depth.
// ----------------------------------------------------------

package tcdm_pkg;

  // data side of the TCDM bus.
  localparam int unsigned data_w = 32;           // one bus word.
  localparam int unsigned be_w   = data_w / 8;   // one enable per byte.

  // address seen by a single bank.
  // counted in words and no bit of it picks the bank, because the
  // channel-to-bank mapping comes from the rotation only.
  localparam int unsigned addr_w = 8;

  // defaults for the top level parameters.
  localparam int unsigned bank_depth_default = 256;  // words per bank.
  localparam int unsigned nb_chan_default    = 4;    // channels and banks.

endpackage : tcdm_pkg

/* tcdm_reorder.sv */
// ----------------------------------------------------------
// tcdm channel reorder
// Rotates channel requests onto banks by the current order,
// returns grants on the same mapping and steers responses
// with the mapping captured at acceptance.
// ----------------------------------------------------------

module tcdm_reorder #(
  parameter int unsigned NB_CHAN = tcdm_pkg::nb_chan_default
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    clear,
  input  logic [$clog2(NB_CHAN)-1:0]              order,
  // channel side.
  input  logic [NB_CHAN-1:0]                      in_req,
  input  logic [NB_CHAN-1:0][tcdm_pkg::addr_w-1:0] in_add,
  input  logic [NB_CHAN-1:0]                      in_wen,
  input  logic [NB_CHAN-1:0][tcdm_pkg::be_w-1:0]   in_be,
  input  logic [NB_CHAN-1:0][tcdm_pkg::data_w-1:0] in_data,
  output logic [NB_CHAN-1:0]                      in_gnt,
  output logic [NB_CHAN-1:0][tcdm_pkg::data_w-1:0] in_r_data,
  output logic [NB_CHAN-1:0]                      in_r_valid,
  // bank side.
  output logic [NB_CHAN-1:0]                      out_req,
  output logic [NB_CHAN-1:0][tcdm_pkg::addr_w-1:0] out_add,
  output logic [NB_CHAN-1:0]                      out_wen,
  output logic [NB_CHAN-1:0][tcdm_pkg::be_w-1:0]   out_be,
  output logic [NB_CHAN-1:0][tcdm_pkg::data_w-1:0] out_data,
  input  logic [NB_CHAN-1:0]                      out_gnt,
  input  logic [NB_CHAN-1:0][tcdm_pkg::data_w-1:0] out_r_data,
  input  logic [NB_CHAN-1:0]                      out_r_valid
);

  localparam int unsigned ORDER_W = $clog2(NB_CHAN);

  logic [NB_CHAN-1:0][ORDER_W-1:0] winner;    // channel feeding each bank.
  logic [NB_CHAN-1:0][ORDER_W-1:0] winner_q;  // channel owed a response.
  logic [NB_CHAN-1:0]              issued_q;  // bank accepted last cycle.

  // bank i serves channel (order + i) mod NB_CHAN.
  always_comb begin : winner_comb
    for (int j = 0; j < NB_CHAN; j++) begin
      winner[j] = order + ORDER_W'(j);  // truncation does the modulo.
    end
  end

  for (genvar i = 0; i < NB_CHAN; i++) begin : gen_bank_side

    // request path is pure wiring.
    assign out_req[i]  = in_req[winner[i]];
    assign out_add[i]  = in_add[winner[i]];
    assign out_wen[i]  = in_wen[winner[i]];
    assign out_be[i]   = in_be[winner[i]];
    assign out_data[i] = in_data[winner[i]];

    // remember who was served since order may move before the response.
    always_ff @(posedge clk_i or negedge rst_ni) begin : issue_reg
      if (!rst_ni) begin
        winner_q[i] <= '0;
        issued_q[i] <= 1'b0;
      end else if (clear) begin
        winner_q[i] <= '0;
        issued_q[i] <= 1'b0;  // drop whatever was in flight.
      end else begin
        winner_q[i] <= winner[i];
        issued_q[i] <= out_req[i] & out_gnt[i];
      end
    end

    // a bank only answers what this block handed it.
    resp_owned_a : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      out_r_valid[i] |-> issued_q[i]
    ) else $error("bank %0d answered without a registered request.", i);

  end : gen_bank_side

  // grants go back on the live mapping and responses on the captured one.
  always_comb begin : resp_comb
    in_gnt     = '0;
    in_r_data  = '0;
    in_r_valid = '0;
    for (int k = 0; k < NB_CHAN; k++) begin
      in_gnt[winner[k]]       = out_gnt[k];
      in_r_data[winner_q[k]]  = out_r_data[k];
      in_r_valid[winner_q[k]] = out_r_valid[k] & issued_q[k];
    end
  end

endmodule : tcdm_reorder

/* tcdm_rotation_ctrl.sv */
// ----------------------------------------------------------
// tcdm rotation controller
// Wrapping order counter that moves one step after every
// cycle in which a bank served a request.
// ----------------------------------------------------------

module tcdm_rotation_ctrl #(
  parameter int unsigned NB_CHAN = tcdm_pkg::nb_chan_default
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear,     // sync return to order 0.
  input  logic                       enable,    // allow the order to move.
  input  logic [NB_CHAN-1:0]         bank_gnt,  // grants seen at the banks.
  output logic [$clog2(NB_CHAN)-1:0] order
);

  localparam int unsigned ORDER_W = $clog2(NB_CHAN);

  logic served;  // some bank took a request this cycle.

  assign served = |bank_gnt;

  // counter wraps for free since NB_CHAN is a power of two.
  always_ff @(posedge clk_i or negedge rst_ni) begin : order_reg
    if (!rst_ni) begin
      order <= '0;
    end else if (clear) begin
      order <= '0;
    end else if (enable && served) begin
      order <= order + ORDER_W'(1);  // one step per busy cycle.
    end
  end

  // a disabled controller holds its rotation across cycles.
  order_hold_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (!enable && !clear) |=> $stable(order)
  ) else $error("rotation order moved while disabled.");

endmodule : tcdm_rotation_ctrl

/* tcdm_subsystem.sv */
// ----------------------------------------------------------
// tcdm subsystem
// Channel reorder in front of NB_CHAN banks, with a rotation
// controller that moves the channel-to-bank mapping as
// traffic is served.
// ----------------------------------------------------------

module tcdm_subsystem #(
  parameter int unsigned NB_CHAN    = tcdm_pkg::nb_chan_default,
  parameter int unsigned BANK_DEPTH = tcdm_pkg::bank_depth_default
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    clear,
  input  logic                                    rotate_en,
  input  logic [NB_CHAN-1:0]                      req,
  input  logic [NB_CHAN-1:0][tcdm_pkg::addr_w-1:0] add,
  input  logic [NB_CHAN-1:0]                      wen,
  input  logic [NB_CHAN-1:0][tcdm_pkg::be_w-1:0]   be,
  input  logic [NB_CHAN-1:0][tcdm_pkg::data_w-1:0] data,
  output logic [NB_CHAN-1:0]                      gnt,
  output logic [NB_CHAN-1:0][tcdm_pkg::data_w-1:0] r_data,
  output logic [NB_CHAN-1:0]                      r_valid,
  output logic [$clog2(NB_CHAN)-1:0]              order
);

  // bank side of the reorder block.
  logic [NB_CHAN-1:0]                       bank_req;
  logic [NB_CHAN-1:0][tcdm_pkg::addr_w-1:0] bank_add;
  logic [NB_CHAN-1:0]                       bank_wen;
  logic [NB_CHAN-1:0][tcdm_pkg::be_w-1:0]   bank_be;
  logic [NB_CHAN-1:0][tcdm_pkg::data_w-1:0] bank_data;
  logic [NB_CHAN-1:0]                       bank_gnt;
  logic [NB_CHAN-1:0][tcdm_pkg::data_w-1:0] bank_r_data;
  logic [NB_CHAN-1:0]                       bank_r_valid;

  tcdm_rotation_ctrl #(
    .NB_CHAN (NB_CHAN)
  ) i_rotation_ctrl (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear    (clear),
    .enable   (rotate_en),
    .bank_gnt (bank_gnt),   // served traffic drives the rotation.
    .order    (order)
  );

  tcdm_reorder #(
    .NB_CHAN (NB_CHAN)
  ) i_reorder (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear       (clear),
    .order       (order),
    .in_req      (req),
    .in_add      (add),
    .in_wen      (wen),
    .in_be       (be),
    .in_data     (data),
    .in_gnt      (gnt),
    .in_r_data   (r_data),
    .in_r_valid  (r_valid),
    .out_req     (bank_req),
    .out_add     (bank_add),
    .out_wen     (bank_wen),
    .out_be      (bank_be),
    .out_data    (bank_data),
    .out_gnt     (bank_gnt),
    .out_r_data  (bank_r_data),
    .out_r_valid (bank_r_valid)
  );

  for (genvar i = 0; i < NB_CHAN; i++) begin : gen_bank
    tcdm_bank #(
      .BANK_DEPTH (BANK_DEPTH)
    ) i_bank (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .clear   (clear),
      .req     (bank_req[i]),
      .add     (bank_add[i]),
      .wen     (bank_wen[i]),
      .be      (bank_be[i]),
      .data    (bank_data[i]),
      .gnt     (bank_gnt[i]),
      .r_data  (bank_r_data[i]),
      .r_valid (bank_r_valid[i])
    );
  end : gen_bank

endmodule : tcdm_subsystem
